// ==== hw/mips_macros.svh ====
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// datapath and address width
`define XLEN 32

// word-addressed memories, byte address bits [1:0] dropped
`define IMEM_WORDS 64
`define DMEM_WORDS 64

// architectural registers, 5-bit numbers
`define REG_COUNT 32

// first fetch address once rst falls
`define RESET_PC 32'h0000_0000

`endif

// ==== hw/mipsPkg.sv ====
package mipsPkg;

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'b000000,
        OP_BEQ   = 6'b000100,
        OP_BNE   = 6'b000101,
        OP_ADDI  = 6'b001000,
        OP_SLTI  = 6'b001010,
        OP_ANDI  = 6'b001100,
        OP_ORI   = 6'b001101,
        OP_XORI  = 6'b001110,
        OP_LW    = 6'b100011,
        OP_SW    = 6'b101011
    } opcode_t;

    // funct field of R-type, instr[5:0]
    typedef enum logic [5:0] {
        FN_NOP  = 6'b000000,
        FN_ADD  = 6'b100000,
        FN_SUB  = 6'b100010,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_XNOR = 6'b100111,
        FN_SLT  = 6'b101010
    } funct_t;

    // bit 2 set means B inverted and carry in for the adder
    typedef enum logic [2:0] {
        ALU_AND  = 3'b000,
        ALU_OR   = 3'b001,
        ALU_ADD  = 3'b010,
        ALU_XOR  = 3'b011,
        ALU_XNOR = 3'b100,
        ALU_SUB  = 3'b101,
        ALU_SLT  = 3'b110
    } aluOp_t;

    typedef enum logic [1:0] {
        FWD_REGFILE  = 2'b00,
        FWD_FROM_WB  = 2'b01,
        FWD_FROM_MEM = 2'b10
    } fwdSel_t;

    typedef struct packed {
        logic   regWrite;
        logic   memToReg;   // result comes from data memory
        logic   memWrite;
        aluOp_t aluOp;
        logic   aluSrcImm;  // B operand is the immediate
        logic   zeroExt;
        logic   regDst;     // write rd, else rt
        logic   branchEq;
        logic   branchNe;
    } ctrl_t;

endpackage

// ==== hw/hazardIf.sv ====
`timescale 1ns/10ps

interface hazardIf import mipsPkg::*; (input logic clk);

    // decode stage
    logic [4:0] rsD;
    logic [4:0] rtD;
    logic       branchD;

    // execute stage
    logic [4:0] rsE;
    logic [4:0] rtE;
    logic [4:0] writeRegE;
    logic       regWriteE;
    logic       memToRegE;

    // memory and writeback stages
    logic [4:0] writeRegM;
    logic       regWriteM;
    logic       memToRegM;
    logic [4:0] writeRegW;
    logic       regWriteW;

    // controls from the hazard unit
    logic    stallF;
    logic    stallD;
    logic    flushE;
    logic    forwardAD;
    logic    forwardBD;
    fwdSel_t forwardAE;
    fwdSel_t forwardBE;

    modport pipe (
        output rsD, rtD, branchD, rsE, rtE, writeRegE, regWriteE, memToRegE,
               writeRegM, regWriteM, memToRegM, writeRegW, regWriteW,
        input  stallF, stallD, flushE, forwardAD, forwardBD, forwardAE, forwardBE
    );

    modport hazard (
        input  clk, rsD, rtD, branchD, rsE, rtE, writeRegE, regWriteE, memToRegE,
               writeRegM, regWriteM, memToRegM, writeRegW, regWriteW,
        output stallF, stallD, flushE, forwardAD, forwardBD, forwardAE, forwardBE
    );

endinterface

// ==== hw/regFile.sv ====
`timescale 1ns/10ps
`include "mips_macros.svh"

module regFile (
    input  logic             clk,
    input  logic             rst,
    input  logic [4:0]       readA,
    input  logic [4:0]       readB,
    output logic [`XLEN-1:0] rdA,
    output logic [`XLEN-1:0] rdB,
    input  logic             writeEn,
    input  logic [4:0]       writeAddr,
    input  logic [`XLEN-1:0] writeData
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeAddr] <= writeData;
        end
    end

    // $0 is hardwired, writeback bypasses straight into decode
    assign rdA = (readA == 5'd0) ? '0 :
                 (writeEn && writeAddr == readA) ? writeData : regs[readA];
    assign rdB = (readB == 5'd0) ? '0 :
                 (writeEn && writeAddr == readB) ? writeData : regs[readB];

    assert property (@(posedge clk) disable iff (rst) !$isunknown(writeEn));

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/10ps
`include "mips_macros.svh"

module alu import mipsPkg::*; (
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    input  aluOp_t           op,
    output logic [`XLEN-1:0] y
);

    logic [`XLEN-1:0] bMod, sum;
    logic             lessThan;

    // one adder, top op bit gives a - b
    assign bMod = op[2] ? ~b : b;
    assign sum  = a + bMod + {{(`XLEN-1){1'b0}}, op[2]};

    // signed compare, sign of a wins when signs differ
    assign lessThan = (a[`XLEN-1] ^ b[`XLEN-1]) ? a[`XLEN-1] : sum[`XLEN-1];

    always_comb begin
        case (op)
            ALU_AND:          y = a & b;
            ALU_OR:           y = a | b;
            ALU_XOR:          y = a ^ b;
            ALU_XNOR:         y = ~(a ^ b);
            ALU_ADD, ALU_SUB: y = sum;
            ALU_SLT:          y = {{(`XLEN-1){1'b0}}, lessThan};
            default:          y = '0;
        endcase
    end

endmodule

// ==== hw/fetchDecode.sv ====
`timescale 1ns/10ps
`include "mips_macros.svh"

module fetchDecode import mipsPkg::*; (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           imemWe,
    input  logic [$clog2(`IMEM_WORDS)-1:0] imemAddr,
    input  logic [`XLEN-1:0]               imemData,
    hazardIf.pipe                          hz,
    input  logic [`XLEN-1:0]               rdA,
    input  logic [`XLEN-1:0]               rdB,
    output logic [4:0]                     readA,
    output logic [4:0]                     readB,
    input  logic [`XLEN-1:0]               aluOutM,
    output ctrl_t                          ctrlD,
    output logic [`XLEN-1:0]               srcAD,
    output logic [`XLEN-1:0]               srcBD,
    output logic [`XLEN-1:0]               immD,
    output logic [4:0]                     rsD2,
    output logic [4:0]                     rtD2,
    output logic [4:0]                     rdD
);

    localparam int IMEM_AW = $clog2(`IMEM_WORDS);

    logic [`XLEN-1:0] imem [`IMEM_WORDS];
    logic [`XLEN-1:0] pcF, pcPlus4F, instrF;
    logic [`XLEN-1:0] instrD, pcPlus4D;
    logic [`XLEN-1:0] signImm, pcBranchD;
    logic             pcSrcD;
    opcode_t          op;
    funct_t           fn;

    // program load port, only open during reset
    always_ff @(posedge clk) begin
        if (rst && imemWe)
            imem[imemAddr] <= imemData;
    end

    assign instrF   = imem[pcF[IMEM_AW+1:2]];
    assign pcPlus4F = pcF + `XLEN'd4;

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            pcF <= `RESET_PC;
        else if (!hz.stallF)
            pcF <= pcSrcD ? pcBranchD : pcPlus4F;
    end

    // IF/ID, a taken branch squashes the fetched slot
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            instrD   <= '0;
            pcPlus4D <= '0;
        end else if (!hz.stallD) begin
            instrD   <= pcSrcD ? '0 : instrF;
            pcPlus4D <= pcSrcD ? '0 : pcPlus4F;
        end
    end

    assign op = opcode_t'(instrD[31:26]);
    assign fn = funct_t'(instrD[5:0]);

    always_comb begin
        ctrlD = '0;
        case (op)
            OP_RTYPE: begin
                ctrlD.regWrite = 1'b1;
                ctrlD.regDst   = 1'b1;
                case (fn)
                    FN_ADD:  ctrlD.aluOp = ALU_ADD;
                    FN_SUB:  ctrlD.aluOp = ALU_SUB;
                    FN_AND:  ctrlD.aluOp = ALU_AND;
                    FN_OR:   ctrlD.aluOp = ALU_OR;
                    FN_XOR:  ctrlD.aluOp = ALU_XOR;
                    FN_XNOR: ctrlD.aluOp = ALU_XNOR;
                    FN_SLT:  ctrlD.aluOp = ALU_SLT;
                    default: ctrlD = '0;    // nop and unknown functs
                endcase
            end
            OP_ADDI, OP_SLTI, OP_LW: begin
                ctrlD.regWrite  = 1'b1;
                ctrlD.aluSrcImm = 1'b1;
                ctrlD.memToReg  = (op == OP_LW);
                ctrlD.aluOp     = (op == OP_SLTI) ? ALU_SLT : ALU_ADD;
            end
            OP_ANDI, OP_ORI, OP_XORI: begin
                ctrlD.regWrite  = 1'b1;
                ctrlD.aluSrcImm = 1'b1;
                ctrlD.zeroExt   = 1'b1;
                ctrlD.aluOp     = (op == OP_ANDI) ? ALU_AND :
                                  (op == OP_ORI)  ? ALU_OR  : ALU_XOR;
            end
            OP_SW: begin
                ctrlD.memWrite  = 1'b1;
                ctrlD.aluSrcImm = 1'b1;
                ctrlD.aluOp     = ALU_ADD;
            end
            OP_BEQ:  ctrlD.branchEq = 1'b1;
            OP_BNE:  ctrlD.branchNe = 1'b1;
            default: ctrlD = '0;
        endcase
    end

    assign signImm   = {{(`XLEN-16){instrD[15]}}, instrD[15:0]};
    assign immD      = ctrlD.zeroExt ? {{(`XLEN-16){1'b0}}, instrD[15:0]} : signImm;
    assign pcBranchD = pcPlus4D + (signImm << 2);

    assign readA = instrD[25:21];
    assign readB = instrD[20:16];
    assign rsD2  = instrD[25:21];
    assign rtD2  = instrD[20:16];
    assign rdD   = instrD[15:11];

    // early branch compare, ALU result of the memory stage forwarded
    assign srcAD  = hz.forwardAD ? aluOutM : rdA;
    assign srcBD  = hz.forwardBD ? aluOutM : rdB;
    assign pcSrcD = (ctrlD.branchEq && srcAD == srcBD) ||
                    (ctrlD.branchNe && srcAD != srcBD);

    assign hz.rsD     = instrD[25:21];
    assign hz.rtD     = instrD[20:16];
    assign hz.branchD = ctrlD.branchEq | ctrlD.branchNe;

    assert property (@(posedge clk) disable iff (rst) pcF[1:0] == 2'b00);

endmodule

// ==== hw/executeMem.sv ====
`timescale 1ns/10ps
`include "mips_macros.svh"

module executeMem import mipsPkg::*; (
    input  logic             clk,
    input  logic             rst,
    hazardIf.pipe            hz,
    input  ctrl_t            ctrlD,
    input  logic [`XLEN-1:0] srcAD,
    input  logic [`XLEN-1:0] srcBD,
    input  logic [`XLEN-1:0] immD,
    input  logic [4:0]       rsD2,
    input  logic [4:0]       rtD2,
    input  logic [4:0]       rdD,
    output logic [`XLEN-1:0] aluOutM,
    output logic             regWriteW,
    output logic [4:0]       writeRegW,
    output logic [`XLEN-1:0] resultW
);

    localparam int DMEM_AW = $clog2(`DMEM_WORDS);

    ctrl_t            ctrlE;
    logic [`XLEN-1:0] rdAE, rdBE, immE;
    logic [4:0]       rsE, rtE, rdE, writeRegE;
    logic [`XLEN-1:0] srcAE, srcBE, writeDataE, aluOutE;

    logic             regWriteM, memToRegM, memWriteM;
    logic [`XLEN-1:0] writeDataM, readDataM;
    logic [4:0]       writeRegM;
    logic [`XLEN-1:0] dmem [`DMEM_WORDS];

    logic             memToRegW;
    logic [`XLEN-1:0] readDataW, aluOutW;

    // control bits of all three stages, bubble inserted on flushE
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctrlE     <= '0;
            regWriteM <= 1'b0;
            memToRegM <= 1'b0;
            memWriteM <= 1'b0;
            regWriteW <= 1'b0;
            memToRegW <= 1'b0;
        end else begin
            ctrlE     <= hz.flushE ? '0 : ctrlD;
            regWriteM <= ctrlE.regWrite;
            memToRegM <= ctrlE.memToReg;
            memWriteM <= ctrlE.memWrite;
            regWriteW <= regWriteM;
            memToRegW <= memToRegM;
        end
    end

    always_ff @(posedge clk) begin
        rdAE       <= srcAD;
        rdBE       <= srcBD;
        immE       <= immD;
        rsE        <= rsD2;
        rtE        <= rtD2;
        rdE        <= rdD;
        aluOutM    <= aluOutE;
        writeDataM <= writeDataE;
        writeRegM  <= writeRegE;
        readDataW  <= readDataM;
        aluOutW    <= aluOutM;
        writeRegW  <= writeRegM;
    end

    // memory stage result preferred over writeback
    always_comb begin
        case (hz.forwardAE)
            FWD_FROM_MEM: srcAE = aluOutM;
            FWD_FROM_WB:  srcAE = resultW;
            default:      srcAE = rdAE;
        endcase
        case (hz.forwardBE)
            FWD_FROM_MEM: writeDataE = aluOutM;
            FWD_FROM_WB:  writeDataE = resultW;
            default:      writeDataE = rdBE;
        endcase
    end

    assign srcBE     = ctrlE.aluSrcImm ? immE : writeDataE;
    assign writeRegE = ctrlE.regDst ? rdE : rtE;

    alu aluUnit (
        .a  (srcAE),
        .b  (srcBE),
        .op (ctrlE.aluOp),
        .y  (aluOutE)
    );

    // data memory, async read and write at the clock edge
    always_ff @(posedge clk) begin
        if (memWriteM)
            dmem[aluOutM[DMEM_AW+1:2]] <= writeDataM;
    end

    assign readDataM = dmem[aluOutM[DMEM_AW+1:2]];
    assign resultW   = memToRegW ? readDataW : aluOutW;

    assign hz.rsE       = rsE;
    assign hz.rtE       = rtE;
    assign hz.writeRegE = writeRegE;
    assign hz.regWriteE = ctrlE.regWrite;
    assign hz.memToRegE = ctrlE.memToReg;
    assign hz.writeRegM = writeRegM;
    assign hz.regWriteM = regWriteM;
    assign hz.memToRegM = memToRegM;
    assign hz.writeRegW = writeRegW;
    assign hz.regWriteW = regWriteW;

    // bubble reaches memory two edges after the flush
    assert property (@(posedge clk) disable iff (rst) hz.flushE |-> ##2 !memWriteM);

endmodule

// ==== hw/hazardUnit.sv ====
`timescale 1ns/10ps

module hazardUnit import mipsPkg::*; (
    hazardIf.hazard hz
);

    logic lwStall, branchStall, stall;

    function automatic fwdSel_t pickFwd(logic [4:0] src);
        fwdSel_t sel;
        sel = FWD_REGFILE;
        if (src != 5'd0 && hz.regWriteM && src == hz.writeRegM)
            sel = FWD_FROM_MEM;
        else if (src != 5'd0 && hz.regWriteW && src == hz.writeRegW)
            sel = FWD_FROM_WB;
        return sel;
    endfunction

    always_comb begin
        hz.forwardAE = pickFwd(hz.rsE);
        hz.forwardBE = pickFwd(hz.rtE);
    end

    // decode side only sees the memory stage
    assign hz.forwardAD = (hz.rsD != 5'd0) && hz.regWriteM && (hz.rsD == hz.writeRegM);
    assign hz.forwardBD = (hz.rtD != 5'd0) && hz.regWriteM && (hz.rtD == hz.writeRegM);

    // load in execute feeding decode
    assign lwStall = hz.memToRegE &&
                     ((hz.writeRegE == hz.rsD) || (hz.writeRegE == hz.rtD));

    // branch operand still in execute or still being loaded
    assign branchStall = hz.branchD &&
        ((hz.regWriteE && ((hz.writeRegE == hz.rsD) || (hz.writeRegE == hz.rtD))) ||
         (hz.memToRegM && ((hz.writeRegM == hz.rsD) || (hz.writeRegM == hz.rtD))));

    assign stall     = lwStall || branchStall;
    assign hz.stallF = stall;
    assign hz.stallD = stall;
    assign hz.flushE = stall;

    assert property (@(posedge hz.clk) hz.stallF == hz.stallD);

endmodule

// ==== hw/mipsCore.sv ====
`timescale 1ns/10ps
`include "mips_macros.svh"

module mipsCore import mipsPkg::*; (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           imemWe,
    input  logic [$clog2(`IMEM_WORDS)-1:0] imemAddr,
    input  logic [`XLEN-1:0]               imemData,
    output logic                           wbValid,
    output logic [4:0]                     wbReg,
    output logic [`XLEN-1:0]               wbData
);

    ctrl_t            ctrlD;
    logic [`XLEN-1:0] srcAD, srcBD, immD;
    logic [4:0]       rsD, rtD, rdD;
    logic [4:0]       readA, readB;
    logic [`XLEN-1:0] rdA, rdB;
    logic [`XLEN-1:0] aluOutM, resultW;
    logic             regWriteW;
    logic [4:0]       writeRegW;

    hazardIf hz (.clk(clk));

    fetchDecode fd (
        .clk(clk), .rst(rst),
        .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
        .hz(hz),
        .rdA(rdA), .rdB(rdB), .readA(readA), .readB(readB),
        .aluOutM(aluOutM),
        .ctrlD(ctrlD), .srcAD(srcAD), .srcBD(srcBD), .immD(immD),
        .rsD2(rsD), .rtD2(rtD), .rdD(rdD)
    );

    regFile rf (
        .clk(clk), .rst(rst),
        .readA(readA), .readB(readB), .rdA(rdA), .rdB(rdB),
        .writeEn(regWriteW), .writeAddr(writeRegW), .writeData(resultW)
    );

    executeMem em (
        .clk(clk), .rst(rst), .hz(hz),
        .ctrlD(ctrlD), .srcAD(srcAD), .srcBD(srcBD), .immD(immD),
        .rsD2(rsD), .rtD2(rtD), .rdD(rdD),
        .aluOutM(aluOutM),
        .regWriteW(regWriteW), .writeRegW(writeRegW), .resultW(resultW)
    );

    hazardUnit hu (.hz(hz));

    // retiring register write, one pulse per instruction
    assign wbValid = regWriteW;
    assign wbReg   = writeRegW;
    assign wbData  = resultW;

endmodule

// ==== bench/coreTb.sv ====
`timescale 1ns/10ps
`include "mips_macros.svh"

module coreTb import mipsPkg::*; ();

    logic                           clk;
    logic                           rst;
    logic                           imemWe;
    logic [$clog2(`IMEM_WORDS)-1:0] imemAddr;
    logic [`XLEN-1:0]               imemData;
    logic                           wbValid;
    logic [4:0]                     wbReg;
    logic [`XLEN-1:0]               wbData;

    logic [`XLEN-1:0] prog [16];
    logic [4:0]       expReg [64];
    logic [`XLEN-1:0] expVal [64];
    int               progLen;
    int               expCount;
    int               idx;
    int               errors;
    int               testsRun;
    int               testsFailed;
    logic [31:0]      rngState;

    mipsCore dut (
        .clk(clk), .rst(rst),
        .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
        .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
    );

    always #10 clk = ~clk;

    // position in the expected write list
    always @(posedge clk) begin
        if (rst)
            idx <= 0;
        else if (wbValid)
            idx <= idx + 1;
    end

    assert property (@(posedge clk) rst |-> !wbValid)
        else begin
            $display("wbValid pulsed while reset was held");
            errors++;
        end

    // also catches writes from the final self loop
    assert property (@(posedge clk) disable iff (rst) wbValid |-> idx < expCount)
        else begin
            $display("unexpected write to r%0d after all expected writes", $sampled(wbReg));
            errors++;
        end

    assert property (@(posedge clk) disable iff (rst)
                     wbValid && idx < expCount |-> wbReg == expReg[idx])
        else begin
            $display("[ERROR] wbReg got %h expected %h", $sampled(wbReg),
                     expReg[$sampled(idx)]);
            errors++;
        end

    assert property (@(posedge clk) disable iff (rst)
                     wbValid && idx < expCount |-> wbData == expVal[idx])
        else begin
            $display("[ERROR] wbData got %h expected %h", $sampled(wbData),
                     expVal[$sampled(idx)]);
            errors++;
        end

    function automatic logic [31:0] rType(funct_t fn, logic [4:0] rd, logic [4:0] rs,
                                          logic [4:0] rt);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] iType(opcode_t op, logic [4:0] rt, logic [4:0] rs,
                                          logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] xorshift(logic [31:0] s);
        s ^= s << 13;
        s ^= s >> 17;
        s ^= s << 5;
        return s;
    endfunction

    function automatic logic [15:0] randImm();
        rngState = xorshift(rngState);
        return rngState[15:0];
    endfunction

    task automatic emit(input logic [31:0] instr);
        prog[progLen] = instr;
        progLen++;
    endtask

    // ISA-level run of prog recording every register write in order
    task automatic modelProgram();
        logic [31:0] r [32];
        logic [31:0] mem [64];
        logic [31:0] instr, a, b, sImm, zImm, v, addr;
        logic [4:0]  dst;
        logic        wr;
        int          pc;
        int          next;
        for (int i = 0; i < 32; i++)
            r[i] = '0;
        pc = 0;
        expCount = 0;
        for (int steps = 0; steps < 100; steps++) begin
            instr = prog[pc];
            a     = r[instr[25:21]];
            b     = r[instr[20:16]];
            sImm  = {{16{instr[15]}}, instr[15:0]};
            zImm  = {16'd0, instr[15:0]};
            addr  = a + sImm;
            next  = pc + 1;
            wr    = 1'b1;
            dst   = instr[20:16];
            v     = '0;
            case (instr[31:26])
                OP_RTYPE: begin
                    dst = instr[15:11];
                    case (instr[5:0])
                        FN_ADD:  v = a + b;
                        FN_SUB:  v = a - b;
                        FN_AND:  v = a & b;
                        FN_OR:   v = a | b;
                        FN_XOR:  v = a ^ b;
                        FN_XNOR: v = ~(a ^ b);
                        FN_SLT:  v = {31'd0, $signed(a) < $signed(b)};
                        default: wr = 1'b0;
                    endcase
                end
                OP_ADDI: v = a + sImm;
                OP_SLTI: v = {31'd0, $signed(a) < $signed(sImm)};
                OP_ANDI: v = a & zImm;
                OP_ORI:  v = a | zImm;
                OP_XORI: v = a ^ zImm;
                OP_LW:   v = mem[addr[7:2]];
                OP_SW: begin
                    mem[addr[7:2]] = b;
                    wr = 1'b0;
                end
                OP_BEQ: begin
                    wr = 1'b0;
                    if (a == b)
                        next = pc + 1 + $signed(instr[15:0]);
                end
                OP_BNE: begin
                    wr = 1'b0;
                    if (a != b)
                        next = pc + 1 + $signed(instr[15:0]);
                end
                default: wr = 1'b0;
            endcase
            if (wr) begin
                expReg[expCount] = dst;
                expVal[expCount] = v;
                expCount++;
                if (dst != 5'd0)
                    r[dst] = v;     // $0 stays zero
            end
            if (next == pc)
                break;
            pc = next;
        end
    endtask

    task automatic runTest(input string name);
        int cycles;
        int errorsBefore;
        errorsBefore = errors;
        @(negedge clk);
        rst = 1'b1;
        modelProgram();
        // program goes in during the 16 reset cycles
        for (int i = 0; i < 16; i++) begin
            imemWe   = (i < progLen);
            imemAddr = i[5:0];
            imemData = prog[i];
            @(negedge clk);
        end
        imemWe = 1'b0;
        rst    = 1'b0;
        cycles = 0;
        while (idx < expCount && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        if (idx < expCount) begin
            $display("test %s timed out with %0d of %0d writes seen", name, idx, expCount);
            errors++;
        end
        cycles = 0;
        while (cycles < 30) begin   // self loop must stay quiet
            @(negedge clk);
            cycles++;
        end
        testsRun++;
        if (errors != errorsBefore) begin
            testsFailed++;
            $display("test %s failed", name);
        end else begin
            $display("test %s passed, %0d writes", name, expCount);
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        imemWe      = 1'b0;
        imemAddr    = '0;
        imemData    = '0;
        errors      = 0;
        testsRun    = 0;
        testsFailed = 0;
        expCount    = 0;
        rngState    = 32'h6894c4a3;

        // dependent chain forwarding from memory and writeback
        progLen = 0;
        emit(iType(OP_ADDI, 5'd1, 5'd0, randImm()));
        emit(iType(OP_ADDI, 5'd2, 5'd0, randImm()));
        emit(rType(FN_ADD, 5'd3, 5'd1, 5'd2));
        emit(rType(FN_SUB, 5'd4, 5'd3, 5'd1));
        emit(rType(FN_AND, 5'd5, 5'd4, 5'd3));
        emit(rType(FN_OR, 5'd6, 5'd5, 5'd4));
        emit(rType(FN_XOR, 5'd7, 5'd6, 5'd3));
        emit(rType(FN_XNOR, 5'd8, 5'd7, 5'd6));
        emit(rType(FN_SLT, 5'd9, 5'd8, 5'd7));
        emit(rType(FN_SLT, 5'd10, 5'd7, 5'd8));
        emit(iType(OP_BEQ, 5'd0, 5'd0, 16'hffff));
        runTest("rtype");

        // sign vs zero extension with the top immediate bit forced on some
        progLen = 0;
        emit(iType(OP_ADDI, 5'd1, 5'd0, randImm() | 16'h8000));
        emit(iType(OP_SLTI, 5'd2, 5'd1, randImm()));
        emit(iType(OP_ANDI, 5'd3, 5'd1, randImm() | 16'h8000));
        emit(iType(OP_ORI, 5'd4, 5'd0, randImm() | 16'h8000));   // upper half stays clear
        emit(iType(OP_XORI, 5'd5, 5'd1, randImm() | 16'h8000));
        emit(iType(OP_ADDI, 5'd6, 5'd5, randImm()));
        emit(iType(OP_SLTI, 5'd7, 5'd0, randImm() | 16'h8000));
        emit(iType(OP_SLTI, 5'd8, 5'd1, 16'h7fff));
        emit(iType(OP_BEQ, 5'd0, 5'd0, 16'hffff));
        runTest("immediate");

        // store then load with the load result used at once
        progLen = 0;
        emit(iType(OP_ADDI, 5'd1, 5'd0, randImm()));
        emit(iType(OP_ADDI, 5'd2, 5'd0, 16'd8));
        emit(iType(OP_SW, 5'd1, 5'd2, 16'd4));
        emit(iType(OP_LW, 5'd3, 5'd2, 16'd4));
        emit(rType(FN_ADD, 5'd4, 5'd3, 5'd1));
        emit(iType(OP_SW, 5'd4, 5'd2, 16'd0));     // store data forwarded
        emit(iType(OP_LW, 5'd5, 5'd2, 16'd0));
        emit(rType(FN_SUB, 5'd6, 5'd5, 5'd3));
        emit(iType(OP_BEQ, 5'd0, 5'd0, 16'hffff));
        runTest("loadstore");

        // taken branches skip one slot with operands from the previous instruction
        progLen = 0;
        emit(iType(OP_ADDI, 5'd1, 5'd0, 16'd5));
        emit(iType(OP_ADDI, 5'd2, 5'd0, 16'd5));
        emit(iType(OP_BEQ, 5'd2, 5'd1, 16'd1));
        emit(iType(OP_ADDI, 5'd3, 5'd0, 16'd1));
        emit(iType(OP_BNE, 5'd2, 5'd1, 16'd1));    // falls through
        emit(iType(OP_ADDI, 5'd4, 5'd0, 16'd2));
        emit(iType(OP_ADDI, 5'd5, 5'd1, 16'hfffb));
        emit(iType(OP_BNE, 5'd1, 5'd5, 16'd1));
        emit(iType(OP_ADDI, 5'd6, 5'd0, 16'd3));
        emit(iType(OP_SW, 5'd1, 5'd0, 16'd0));
        emit(iType(OP_LW, 5'd7, 5'd0, 16'd0));
        emit(iType(OP_BEQ, 5'd1, 5'd7, 16'd1));    // waits on the load
        emit(iType(OP_ADDI, 5'd8, 5'd0, 16'd7));
        emit(iType(OP_ADDI, 5'd9, 5'd0, 16'd9));
        emit(iType(OP_BEQ, 5'd0, 5'd0, 16'hffff));
        runTest("branch");

        // writes to $0 show on the port but never forward
        progLen = 0;
        emit(iType(OP_ADDI, 5'd0, 5'd0, randImm() | 16'h0001));
        emit(rType(FN_ADD, 5'd1, 5'd0, 5'd0));
        emit(iType(OP_ORI, 5'd2, 5'd0, randImm()));
        emit(rType(FN_OR, 5'd3, 5'd0, 5'd2));
        emit(iType(OP_ADDI, 5'd0, 5'd2, 16'd1));
        emit(rType(FN_XOR, 5'd4, 5'd0, 5'd3));
        emit(iType(OP_BEQ, 5'd0, 5'd0, 16'hffff));
        runTest("regzero");

        $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+hw
hw/mipsPkg.sv
hw/hazardIf.sv
hw/regFile.sv
hw/alu.sv
hw/fetchDecode.sv
hw/executeMem.sv
hw/hazardUnit.sv
hw/mipsCore.sv
bench/coreTb.sv

// ==== Makefile ====
SIM    ?= verilator
TOP    ?= coreTb
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' files.f)
HDRS := $(wildcard hw/*.svh)
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): files.f $(SRCS) $(HDRS)
	$(SIM) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f files.f

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^RESULT: PASS$$'

clean:
	rm -rf $(OBJDIR)
